/* Makefile */
SRCS := $(shell cat verilog.f)

obj_dir/Vdiv_unit_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module div_unit_tb -f verilog.f

.PHONY: run clean

run: obj_dir/Vdiv_unit_tb
	./obj_dir/Vdiv_unit_tb

clean:
	rm -rf obj_dir

/* hdl/div_axil_regs.sv */
// AXI4-Lite slave with one write and one read in flight, wstrb and prot are ignored
module div_axil_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  div_pkg::axil_aw_t    aw,
    input  logic                 awvalid,
    output logic                 awready,
    input  div_pkg::axil_w_t     w,
    input  logic                 wvalid,
    output logic                 wready,
    output div_pkg::axil_b_t     b,
    output logic                 bvalid,
    input  logic                 bready,
    input  div_pkg::axil_ar_t    ar,
    input  logic                 arvalid,
    output logic                 arready,
    output div_pkg::axil_r_t     r,
    output logic                 rvalid,
    input  logic                 rready,
    output div_pkg::div_cmd_t    cmd,
    output logic                 start,
    input  logic                 busy,
    input  logic                 complete,
    input  logic                 div_error,
    input  div_pkg::div_result_t result
);
    import div_pkg::*;

    logic              aw_hs;
    logic              w_hs;
    logic              ar_hs;
    logic              aw_held;
    logic              w_held;
    logic [addr_w-1:0] aw_addr_q;
    logic [data_w-1:0] w_data_q;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic              do_write;
    logic              wr_ok;
    logic              launch;
    axi_resp_e         wr_resp;
    logic [data_w-1:0] rd_data;
    axi_resp_e         rd_resp;
    logic              done_q;
    logic              error_q;
    div_result_t       result_q;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    // Address and data may come in either order, the write fires once both are in
    assign wr_addr  = aw_held ? aw_addr_q : aw.addr;
    assign wr_data  = w_held ? w_data_q : w.data;
    assign do_write = (aw_hs || aw_held) && (w_hs || w_held);

    always_comb begin
        wr_resp = okay;
        case (wr_addr)
            reg_dividend, reg_divisor, reg_ctrl: begin
                if (busy) begin
                    wr_resp = slverr;
                end
            end
            // Read-only registers ignore writes
            reg_status, reg_result: ;
            default: wr_resp = slverr;
        endcase
    end

    assign wr_ok  = do_write && (wr_resp == okay);
    assign launch = wr_ok && (wr_addr == reg_ctrl) && wr_data[0];

    always_comb begin
        rd_data = '0;
        rd_resp = okay;
        case (ar.addr)
            reg_dividend: rd_data = cmd.dividend;
            reg_divisor:  rd_data = {{(data_w - divisor_w){1'b0}}, cmd.divisor};
            reg_ctrl:     rd_data = {29'b0, cmd.signed_mode, cmd.byte_mode, 1'b0};
            reg_status:   rd_data = {29'b0, error_q, done_q, busy};
            reg_result:   rd_data = result_q;
            default:      rd_resp = slverr;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            start   <= 1'b0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            // One-cycle ready pulses, held off while a response waits
            awready <= awvalid && !awready && !aw_held && !bvalid;
            wready  <= wvalid && !wready && !w_held && !bvalid;
            arready <= arvalid && !arready && !rvalid;

            if (aw_hs) begin
                aw_held <= 1'b1;
            end
            if (w_hs) begin
                w_held <= 1'b1;
            end
            if (do_write) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            start <= launch;
            // Done is sticky until the next launch
            if (launch) begin
                done_q  <= 1'b0;
                error_q <= 1'b0;
            end else if (complete) begin
                done_q  <= 1'b1;
                error_q <= div_error;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= aw.addr;
        end
        if (w_hs) begin
            w_data_q <= w.data;
        end
        if (do_write) begin
            b.resp <= wr_resp;
        end
        if (wr_ok) begin
            case (wr_addr)
                reg_dividend: cmd.dividend <= wr_data;
                reg_divisor:  cmd.divisor  <= wr_data[divisor_w-1:0];
                reg_ctrl: begin
                    cmd.byte_mode   <= wr_data[1];
                    cmd.signed_mode <= wr_data[2];
                end
                default: ;
            endcase
        end
        if (complete) begin
            result_q <= result;
        end
        if (ar_hs) begin
            r.data <= rd_data;
            r.resp <= rd_resp;
        end
    end

    b_held_until_ready: assert property (@(posedge clk) disable iff (reset)
        (bvalid && !bready) |=> (bvalid && $stable(b)))
        else $error("write response dropped or changed before bready");

    r_held_until_ready: assert property (@(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> (rvalid && $stable(r)))
        else $error("read data dropped or changed before rready");

endmodule

/* hdl/div_operand_prep.sv */
// Purely combinational, cmd must stay stable while the divider samples setup in the start cycle
module div_operand_prep (
    input  div_pkg::div_cmd_t   cmd,
    output div_pkg::div_setup_t setup
);
    import div_pkg::*;

    logic [dividend_w-1:0] dvd_val;
    logic [dividend_w-1:0] dvd_mag;
    logic [divisor_w-1:0]  dsr_val;
    logic [divisor_w-1:0]  dsr_mag;
    logic                  dvd_neg;
    logic                  dsr_neg;
    logic                  signs_differ;
    logic [4:0]            lim_shift;
    logic [dividend_w:0]   bound;
    logic                  over_range;

    // Extend the active operand bits to full width
    always_comb begin
        if (cmd.byte_mode) begin
            if (cmd.signed_mode) begin
                dvd_val = {{16{cmd.dividend[15]}}, cmd.dividend[15:0]};
                dsr_val = {{8{cmd.divisor[7]}}, cmd.divisor[7:0]};
            end else begin
                dvd_val = {16'b0, cmd.dividend[15:0]};
                dsr_val = {8'b0, cmd.divisor[7:0]};
            end
        end else begin
            dvd_val = cmd.dividend;
            dsr_val = cmd.divisor;
        end
    end

    assign dvd_neg      = cmd.signed_mode && dvd_val[dividend_w-1];
    assign dsr_neg      = cmd.signed_mode && dsr_val[divisor_w-1];
    assign signs_differ = dvd_neg ^ dsr_neg;

    // Magnitudes, the most negative value maps to its unsigned twin
    assign dvd_mag = dvd_neg ? -dvd_val : dvd_val;
    assign dsr_mag = dsr_neg ? -dsr_val : dsr_val;

    // Quotient overflows when dividend >= (limit + 1) * divisor
    always_comb begin
        if (cmd.byte_mode) begin
            lim_shift = cmd.signed_mode ? 5'd7 : 5'd8;
        end else begin
            lim_shift = cmd.signed_mode ? 5'd15 : 5'd16;
        end
    end

    always_comb begin
        bound = {{(dividend_w + 1 - divisor_w){1'b0}}, dsr_mag} << lim_shift;
        // Differing signs allow one more step, down to -2^(n-1)
        if (signs_differ) begin
            bound = bound + {{(dividend_w + 1 - divisor_w){1'b0}}, dsr_mag};
        end
    end

    assign over_range = {1'b0, dvd_mag} >= bound;

    always_comb begin
        setup.p_init = {{(p_w - dividend_w){1'b0}}, dvd_mag};
        if (cmd.byte_mode) begin
            setup.d_shift    = {16'b0, dsr_mag[7:0], 8'b0};
            setup.index_init = 4'd7;
        end else begin
            setup.d_shift    = {dsr_mag, 16'b0};
            setup.index_init = 4'd15;
        end
        setup.fault             = (dsr_mag == '0) || over_range;
        setup.quotient_negative = signs_differ;
        setup.dividend_negative = dvd_neg;
    end

endmodule

/* hdl/div_pkg.sv */
// Shared types for the divide unit, with a fixed 32-bit AXI4-Lite register map and full-word writes only
package div_pkg;

    localparam int data_w     = 32;
    localparam int addr_w     = 8;
    localparam int dividend_w = 32;
    localparam int divisor_w  = 16;
    localparam int p_w        = 64;

    // Register map, word aligned
    localparam logic [addr_w-1:0] reg_dividend = 8'h00;
    localparam logic [addr_w-1:0] reg_divisor  = 8'h04;
    localparam logic [addr_w-1:0] reg_ctrl     = 8'h08;
    localparam logic [addr_w-1:0] reg_status   = 8'h0C;
    localparam logic [addr_w-1:0] reg_result   = 8'h10;

    typedef enum logic [1:0] {
        idle,
        iterate,
        restore,
        fix_sign
    } div_state_e;

    // AXI response encoding
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic [dividend_w-1:0] dividend;
        logic [divisor_w-1:0]  divisor;
        logic                  byte_mode;
        logic                  signed_mode;
    } div_cmd_t;

    typedef struct packed {
        logic [p_w-1:0]        p_init;
        logic [dividend_w-1:0] d_shift;
        logic                  fault;
        logic                  quotient_negative;
        logic                  dividend_negative;
        logic [3:0]            index_init;
    } div_setup_t;

    // Quotient sits in the low half of reg_result
    typedef struct packed {
        logic [divisor_w-1:0] remainder;
        logic [divisor_w-1:0] quotient;
    } div_result_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_aw_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_ar_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [data_w/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        axi_resp_e         resp;
    } axil_r_t;

    typedef struct packed {
        axi_resp_e resp;
    } axil_b_t;

endpackage

/* hdl/div_unit_top.sv */
// Divide unit on AXI4-Lite, poll the status register for done since latency depends on mode
module div_unit_top (
    input  logic              clk,
    input  logic              reset,
    input  div_pkg::axil_aw_t aw,
    input  logic              awvalid,
    output logic              awready,
    input  div_pkg::axil_w_t  w,
    input  logic              wvalid,
    output logic              wready,
    output div_pkg::axil_b_t  b,
    output logic              bvalid,
    input  logic              bready,
    input  div_pkg::axil_ar_t ar,
    input  logic              arvalid,
    output logic              arready,
    output div_pkg::axil_r_t  r,
    output logic              rvalid,
    input  logic              rready
);
    import div_pkg::*;

    div_cmd_t    cmd;
    div_setup_t  setup;
    div_result_t result;
    logic        start;
    logic        busy;
    logic        complete;
    logic        div_error;

    div_axil_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .cmd       (cmd),
        .start     (start),
        .busy      (busy),
        .complete  (complete),
        .div_error (div_error),
        .result    (result)
    );

    div_operand_prep u_prep (
        .cmd   (cmd),
        .setup (setup)
    );

    nonrestoring_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cmd       (cmd),
        .setup     (setup),
        .busy      (busy),
        .complete  (complete),
        .div_error (div_error),
        .result    (result)
    );

endmodule

/* hdl/nonrestoring_divider.sv */
// One division at a time, start is ignored unless idle and result is only valid while complete is high
module nonrestoring_divider (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  div_pkg::div_cmd_t    cmd,
    input  div_pkg::div_setup_t  setup,
    output logic                 busy,
    output logic                 complete,
    output logic                 div_error,
    output div_pkg::div_result_t result
);
    import div_pkg::*;

    div_state_e state;
    div_state_e state_next;

    logic [p_w-1:0]        p;
    logic [dividend_w-1:0] d;
    logic [divisor_w-1:0]  q;
    logic [3:0]            idx;
    logic                  byte_mode;
    logic                  signed_mode;
    logic                  q_neg;
    logic                  r_neg;

    logic [divisor_w-1:0]  q_raw;
    logic [divisor_w-1:0]  q_restored;
    logic [p_w-1:0]        p_fixed;
    logic [divisor_w-1:0]  rem_mag;
    logic [divisor_w-1:0]  q_signed;
    logic [divisor_w-1:0]  rem_signed;

    logic                  zero_divisor;
    logic                  unsigned_over;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (start && !setup.fault) begin
                    state_next = iterate;
                end
            end
            iterate: begin
                if (idx == 4'd0) begin
                    state_next = restore;
                end
            end
            restore:  state_next = signed_mode ? fix_sign : idle;
            fix_sign: state_next = idle;
            default:  state_next = idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Datapath loads in the start cycle and then runs on its own registers
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    p           <= setup.p_init;
                    d           <= setup.d_shift;
                    q           <= '0;
                    idx         <= setup.index_init;
                    byte_mode   <= cmd.byte_mode;
                    signed_mode <= cmd.signed_mode;
                    q_neg       <= setup.quotient_negative;
                    r_neg       <= setup.dividend_negative;
                end
            end
            iterate: begin
                // Digit is +1 on a non-negative remainder and -1 otherwise
                if (!p[p_w-1]) begin
                    q[idx] <= 1'b1;
                    p      <= (p << 1) - {{(p_w - dividend_w){1'b0}}, d};
                end else begin
                    p      <= (p << 1) + {{(p_w - dividend_w){1'b0}}, d};
                end
                idx <= idx - 4'd1;
            end
            restore: q <= q_restored;
            default: ;
        endcase
    end

    // Convert the +1/-1 digit string to binary and take one off if the remainder ended negative
    assign q_raw      = q - ~q - {{(divisor_w - 1){1'b0}}, p[p_w-1]};
    assign q_restored = byte_mode ? {8'b0, q_raw[7:0]} : q_raw;
    assign p_fixed    = p[p_w-1] ? p + {{(p_w - dividend_w){1'b0}}, d} : p;
    assign rem_mag    = byte_mode ? {8'b0, p_fixed[15:8]} : p_fixed[31:16];

    // Negating the zero-extended byte remainder also sign extends it
    assign q_signed   = q_neg ? -q : q;
    assign rem_signed = r_neg ? -rem_mag : rem_mag;

    assign busy      = start || (state != idle);
    assign div_error = (state == idle) && start && setup.fault;
    assign complete  = div_error
                     || ((state == restore) && !signed_mode)
                     || (state == fix_sign);

    always_comb begin
        case (state)
            restore: begin
                result.quotient  = q_restored;
                result.remainder = rem_mag;
            end
            fix_sign: begin
                result.quotient  = byte_mode ? {8'b0, q_signed[7:0]} : q_signed;
                result.remainder = rem_signed;
            end
            default:  result = '0;
        endcase
    end

    // Unsigned overflow is the classic test of the dividend's high half against the divisor
    assign zero_divisor  = cmd.byte_mode ? (cmd.divisor[7:0] == '0) : (cmd.divisor == '0);
    assign unsigned_over = cmd.byte_mode ? (cmd.dividend[15:8] >= cmd.divisor[7:0])
                                         : (cmd.dividend[31:16] >= cmd.divisor);

    // A division ends 9, 10, 17 or 18 cycles after its start cycle
    complete_needs_start: assert property (@(posedge clk) disable iff (reset)
        (complete && !div_error) |->
            ($past(start, 9) || $past(start, 10) || $past(start, 17) || $past(start, 18)))
        else $error("complete raised in %s without a matching start", state.name());

    fault_stays_idle: assert property (@(posedge clk) disable iff (reset)
        (state == idle && start && (zero_divisor || (!cmd.signed_mode && unsigned_over)))
        |=> state == idle)
        else $error("faulted start moved the divider to %s", state.name());

    no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> state == idle)
        else $error("start arrived while the divider was in %s", state.name());

endmodule

/* tb/div_unit_tb.sv */
// Drives the divide unit over AXI4-Lite from the falling edge; the random phase uses a fixed xorshift seed
module div_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    typedef struct {
        string       name;
        logic [31:0] dividend;
        logic [15:0] divisor;
        logic        byte_mode;
        logic        signed_mode;
        div_result_t expect_res;
        logic        expect_err;
    } div_case_t;

    logic     clk;
    logic     reset;
    axil_aw_t aw;
    logic     awvalid;
    logic     awready;
    axil_w_t  w;
    logic     wvalid;
    logic     wready;
    axil_b_t  b;
    logic     bvalid;
    logic     bready;
    axil_ar_t ar;
    logic     arvalid;
    logic     arready;
    axil_r_t  r;
    logic     rvalid;
    logic     rready;

    div_case_t rows[$];

    div_unit_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input div_result_t exp,
            input div_result_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected q=%h r=%h, actual q=%h r=%h", name,
                     exp.quotient, exp.remainder, act.quotient, act.remainder);
            end_in_failure();
        end
    endtask

    // Bits are error, done, busy from high to low
    task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected error/done/busy=%b, actual %b", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            $display("FAILED %s: expected resp %s, actual %s", name, exp.name(), act.name());
            end_in_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] exp,
            input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            end_in_failure();
        end
    endtask

    // Ready seen at a falling edge means the handshake happens on the next rising edge
    task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
            input int b_stall, output axi_resp_e resp);
        int   cycles;
        int   i;
        logic aw_fire;
        logic w_fire;
        aw.addr = addr;
        aw.prot = 3'b000;
        w.data  = data;
        w.strb  = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        while (awvalid || wvalid) begin
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(negedge clk);
            if (aw_fire) begin
                awvalid = 1'b0;
            end
            if (w_fire) begin
                wvalid = 1'b0;
            end
            cycles++;
            if (cycles > 50) begin
                $display("write to %h was never accepted on AW or W", addr);
                end_in_failure();
            end
        end
        cycles = 0;
        while (!bvalid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("no write response arrived for address %h", addr);
                end_in_failure();
            end
        end
        resp = b.resp;
        for (i = 0; i < b_stall; i++) begin
            @(negedge clk);
            if (!bvalid || b.resp !== resp) begin
                $display("write response dropped or changed while bready was low");
                end_in_failure();
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [addr_w-1:0] addr, input int r_stall,
            output logic [data_w-1:0] data, output axi_resp_e resp);
        int   cycles;
        int   i;
        logic fire;
        ar.addr = addr;
        ar.prot = 3'b000;
        arvalid = 1'b1;
        fire    = 1'b0;
        cycles  = 0;
        while (!fire) begin
            fire = arready;
            @(negedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("read of %h was never accepted on AR", addr);
                end_in_failure();
            end
        end
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("no read data arrived for address %h", addr);
                end_in_failure();
            end
        end
        data = r.data;
        resp = r.resp;
        for (i = 0; i < r_stall; i++) begin
            @(negedge clk);
            if (!rvalid || r.data !== data || r.resp !== resp) begin
                $display("read data dropped or changed while rready was low");
                end_in_failure();
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_for_done(input string name, input int stall,
            output logic [data_w-1:0] st);
        int        polls;
        axi_resp_e resp;
        polls = 0;
        axil_read(reg_status, stall, st, resp);
        while (!st[1]) begin
            polls++;
            if (polls > 64) begin
                $display("done never came up in the status register for %s", name);
                end_in_failure();
            end
            axil_read(reg_status, stall, st, resp);
        end
        check_resp(name, okay, resp);
    endtask

    // Integer reference with a truncating quotient and a remainder that follows the dividend
    function automatic void model_divide(input logic [31:0] dvd, input logic [15:0] dsr,
            input logic bm, input logic sm, output div_result_t res, output logic err);
        longint num;
        longint den;
        longint quo;
        longint rem;
        longint hi;
        longint lo;
        if (bm) begin
            num = sm ? {{48{dvd[15]}}, dvd[15:0]} : {48'b0, dvd[15:0]};
            den = sm ? {{56{dsr[7]}}, dsr[7:0]} : {56'b0, dsr[7:0]};
            hi  = sm ? 64'sd127 : 64'sd255;
            lo  = sm ? -64'sd128 : 64'sd0;
        end else begin
            num = sm ? {{32{dvd[31]}}, dvd} : {32'b0, dvd};
            den = sm ? {{48{dsr[15]}}, dsr} : {48'b0, dsr};
            hi  = sm ? 64'sd32767 : 64'sd65535;
            lo  = sm ? -64'sd32768 : 64'sd0;
        end
        res = '0;
        err = 1'b1;
        if (den != 0) begin
            quo = num / den;
            rem = num % den;
            err = (quo > hi) || (quo < lo);
            res.quotient  = bm ? {8'b0, quo[7:0]} : quo[15:0];
            res.remainder = rem[15:0];
        end
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input string name, input logic [31:0] dvd, input logic [15:0] dsr,
            input logic bm, input logic sm, input logic [15:0] q, input logic [15:0] rem,
            input logic err);
        div_case_t row;
        row.name                 = name;
        row.dividend             = dvd;
        row.divisor              = dsr;
        row.byte_mode            = bm;
        row.signed_mode          = sm;
        row.expect_res.quotient  = q;
        row.expect_res.remainder = rem;
        row.expect_err           = err;
        rows.push_back(row);
    endtask

    task automatic run_case(input string name, input logic [31:0] dvd, input logic [15:0] dsr,
            input logic bm, input logic sm, input div_result_t exp_res, input logic exp_err,
            input int stall);
        axi_resp_e         resp;
        logic [data_w-1:0] rdata;
        axil_write(reg_dividend, dvd, stall, resp);
        check_resp(name, okay, resp);
        axil_write(reg_divisor, {16'b0, dsr}, stall, resp);
        check_resp(name, okay, resp);
        axil_write(reg_ctrl, {29'b0, sm, bm, 1'b1}, stall, resp);
        check_resp(name, okay, resp);
        wait_for_done(name, stall, rdata);
        check_status(name, {exp_err, 1'b1, 1'b0}, rdata[2:0]);
        if (!exp_err) begin
            axil_read(reg_result, stall, rdata, resp);
            check_resp(name, okay, resp);
            check_result(name, exp_res, rdata);
        end
    endtask

    initial begin
        axi_resp_e         resp;
        logic [data_w-1:0] rdata;
        div_result_t       exp_res;
        logic              exp_err;
        logic [31:0]       seed;
        logic [31:0]       dvd;
        logic [15:0]       dsr;
        logic              bm;
        logic              sm;
        logic [4:0]        sh;
        int                n;

        reset   = 1'b1;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        axil_read(reg_status, 0, rdata, resp);
        check_resp("reset_status", okay, resp);
        check_status("reset_status", 3'b000, rdata[2:0]);

        // Columns are name, dividend, divisor, byte, signed, quotient, remainder and error
        add_row("uw_basic",    32'h000F_4240, 16'h04D2, 1'b0, 1'b0, 16'h032A, 16'h01CC, 1'b0);
        add_row("uw_max_q",    32'hFFFE_FFFF, 16'hFFFF, 1'b0, 1'b0, 16'hFFFF, 16'hFFFE, 1'b0);
        add_row("uw_overflow", 32'h0001_0000, 16'h0001, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1);
        add_row("uw_zero_dvd", 32'h0000_0000, 16'h0007, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0);
        add_row("uw_zero_div", 32'h0000_1234, 16'h0000, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1);
        add_row("ub_basic",    32'hABCD_1234, 16'h3456, 1'b1, 1'b0, 16'h0036, 16'h0010, 1'b0);
        add_row("ub_overflow", 32'h0000_FFFF, 16'h00FF, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1);
        add_row("ub_max_q",    32'h0000_FEFF, 16'h00FF, 1'b1, 1'b0, 16'h00FF, 16'h00FE, 1'b0);
        add_row("ub_zero_div", 32'h0000_0100, 16'h0100, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1);
        add_row("sw_pos_pos",  32'h0000_0064, 16'h0007, 1'b0, 1'b1, 16'h000E, 16'h0002, 1'b0);
        add_row("sw_neg_pos",  32'hFFFF_FF9C, 16'h0007, 1'b0, 1'b1, 16'hFFF2, 16'hFFFE, 1'b0);
        add_row("sw_pos_neg",  32'h0000_0064, 16'hFFF9, 1'b0, 1'b1, 16'hFFF2, 16'h0002, 1'b0);
        add_row("sw_neg_neg",  32'hFFFF_FF9C, 16'hFFF9, 1'b0, 1'b1, 16'h000E, 16'hFFFE, 1'b0);
        add_row("sw_pos_over", 32'h0000_8000, 16'h0001, 1'b0, 1'b1, 16'h0000, 16'h0000, 1'b1);
        add_row("sw_min_q",    32'hFFFE_FFFF, 16'h0002, 1'b0, 1'b1, 16'h8000, 16'hFFFF, 1'b0);
        add_row("sw_neg_over", 32'hFFFE_FFFE, 16'h0002, 1'b0, 1'b1, 16'h0000, 16'h0000, 1'b1);
        add_row("sw_max_q",    32'h0001_7FFF, 16'h0003, 1'b0, 1'b1, 16'h7FFF, 16'h0002, 1'b0);
        add_row("sw_zero_div", 32'h0000_0005, 16'h0000, 1'b0, 1'b1, 16'h0000, 16'h0000, 1'b1);
        add_row("sb_neg_pos",  32'h0000_FF9C, 16'h0007, 1'b1, 1'b1, 16'h00F2, 16'hFFFE, 1'b0);
        add_row("sb_pos_neg",  32'h0000_0064, 16'h00F9, 1'b1, 1'b1, 16'h00F2, 16'h0002, 1'b0);
        add_row("sb_neg_neg",  32'h0000_FF9C, 16'h00F9, 1'b1, 1'b1, 16'h000E, 16'hFFFE, 1'b0);
        add_row("sb_pos_over", 32'h0000_0080, 16'h0001, 1'b1, 1'b1, 16'h0000, 16'h0000, 1'b1);
        add_row("sb_min_q",    32'h0000_FEFF, 16'h0002, 1'b1, 1'b1, 16'h0080, 16'hFFFF, 1'b0);
        add_row("sb_neg_over", 32'h0000_FEFE, 16'h0002, 1'b1, 1'b1, 16'h0000, 16'h0000, 1'b1);
        add_row("sb_max_q",    32'h0000_017F, 16'h0003, 1'b1, 1'b1, 16'h007F, 16'h0002, 1'b0);

        foreach (rows[i]) begin
            run_case(rows[i].name, rows[i].dividend, rows[i].divisor, rows[i].byte_mode,
                     rows[i].signed_mode, rows[i].expect_res, rows[i].expect_err, 0);
        end

        // Shifting the dividend down keeps a fair share of cases in range
        seed = 32'hccfe_01e9;
        for (n = 0; n < 200; n++) begin
            seed = next_random(seed);
            dvd  = seed;
            seed = next_random(seed);
            dsr  = seed[15:0];
            bm   = seed[16];
            sm   = seed[17];
            sh   = seed[22:18];
            if (bm && sm) begin
                dvd[15:0] = $signed(dvd[15:0]) >>> sh[3:0];
            end else if (bm) begin
                dvd[15:0] = dvd[15:0] >> sh[3:0];
            end else if (sm) begin
                dvd = $signed(dvd) >>> sh;
            end else begin
                dvd = dvd >> sh;
            end
            model_divide(dvd, dsr, bm, sm, exp_res, exp_err);
            run_case($sformatf("random_%0d", n), dvd, dsr, bm, sm, exp_res, exp_err, 0);
        end

        // Writes that must bounce while a long signed word division runs
        axil_write(reg_dividend, 32'hFFFE_FFFF, 0, resp);
        check_resp("busy_setup", okay, resp);
        axil_write(reg_divisor, 32'h0000_0002, 0, resp);
        check_resp("busy_setup", okay, resp);
        axil_write(reg_ctrl, 32'h0000_0005, 0, resp);
        check_resp("busy_setup", okay, resp);
        axil_write(reg_dividend, 32'h0000_1234, 0, resp);
        check_resp("busy_dividend_write", slverr, resp);
        axil_write(reg_divisor, 32'h0000_0003, 0, resp);
        check_resp("busy_divisor_write", slverr, resp);
        axil_write(reg_ctrl, 32'h0000_0003, 0, resp);
        check_resp("busy_ctrl_write", slverr, resp);
        axil_read(reg_status, 0, rdata, resp);
        check_status("busy_status", 3'b001, rdata[2:0]);
        wait_for_done("busy_lockout", 0, rdata);
        check_status("busy_lockout", 3'b010, rdata[2:0]);
        axil_read(reg_result, 0, rdata, resp);
        exp_res.quotient  = 16'h8000;
        exp_res.remainder = 16'hFFFF;
        check_result("busy_lockout", exp_res, rdata);
        axil_read(reg_dividend, 0, rdata, resp);
        check_word("busy_dividend_kept", 32'hFFFE_FFFF, rdata);
        axil_read(reg_divisor, 0, rdata, resp);
        check_word("busy_divisor_kept", 32'h0000_0002, rdata);
        // Start reads back as zero, signed mode stays set and byte mode stays clear
        axil_read(reg_ctrl, 0, rdata, resp);
        check_word("busy_ctrl_kept", 32'h0000_0004, rdata);

        axil_read(8'h14, 0, rdata, resp);
        check_resp("unmapped_read", slverr, resp);
        axil_write(8'h20, 32'hDEAD_BEEF, 0, resp);
        check_resp("unmapped_write", slverr, resp);

        // Every response of this division is held off for several cycles
        exp_res.quotient  = 16'h00F2;
        exp_res.remainder = 16'hFFFE;
        run_case("stall_signed_byte", 32'h0000_FF9C, 16'h0007, 1'b1, 1'b1, exp_res, 1'b0, 6);
        axil_write(reg_dividend, 32'h1357_9BDF, 5, resp);
        check_resp("stall_write", okay, resp);
        axil_read(reg_dividend, 7, rdata, resp);
        check_resp("stall_read", okay, resp);
        check_word("stall_read", 32'h1357_9BDF, rdata);

        $display("test passed");
        $finish;
    end

endmodule

/* verilog.f */
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/nonrestoring_divider.sv
hdl/div_axil_regs.sv
hdl/div_unit_top.sv
tb/div_unit_tb.sv
